/* design/ssm_macros.svh */
// ====================
// widths and sizes of the fixed point ssm step
// all arithmetic is signed Q8.8, sums are 32 bit
// SSM_LANE_LAT must match the register depth of ssm_lane
// ====================
`ifndef SSM_MACROS_SVH
`define SSM_MACROS_SVH

// data word, Q8.8
`define SSM_DW 16

// fraction bits, used as the post-multiply shift
`define SSM_FRAC 8

// lanes per tile
`define SSM_LANES 16

// tiles per group, 8 x 16 = 128 state elements
`define SSM_TILES 8

// reducer accumulator width
`define SSM_ACC_W 32

// lane pipeline depth in advancing cycles
// the reducer delays its tags by this amount
`define SSM_LANE_LAT 2

`endif

/* design/ssm_pkg.sv */
// ====================
// shared types for the ssm step
// q_mul wraps on overflow, no saturation
// ====================
`default_nettype none

`include "ssm_macros.svh"

package ssm_pkg;

    // one Q8.8 value
    typedef logic signed [`SSM_DW-1:0] data_t;

    // signed sum inside the reducer
    typedef logic signed [`SSM_ACC_W-1:0] acc_t;

    // one tile, lane i sits at bits [i*SSM_DW +: SSM_DW]
    typedef logic [`SSM_LANES*`SSM_DW-1:0] tile_t;

    // tile position in the group
    typedef logic [$clog2(`SSM_TILES)-1:0] tile_idx_t;

    // fixed point product
    // full 32 bit product, arithmetic shift, keep the low 16 bits
    function automatic data_t q_mul(input data_t a, input data_t b);
        logic signed [2*`SSM_DW-1:0] prod;
        logic signed [2*`SSM_DW-1:0] shifted;
        prod    = a * b;
        shifted = prod >>> `SSM_FRAC;
        return shifted[`SSM_DW-1:0];
    endfunction

endpackage

`default_nettype wire

/* design/ssm_tile_in.sv */
// ====================
// tile input stage, one register stage under advance_i
// xD is taken from the first tile of each group only
// the tile index assumes groups are always complete
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "ssm_macros.svh"

module ssm_tile_in (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire                    advance_i,
    input  wire                    tile_valid_i,
    input  wire ssm_pkg::data_t    dt_i,
    input  wire ssm_pkg::data_t    x_i,
    input  wire ssm_pkg::data_t    da_i,
    input  wire ssm_pkg::data_t    d_i,
    input  wire ssm_pkg::tile_t    b_tile_i,
    input  wire ssm_pkg::tile_t    c_tile_i,
    input  wire ssm_pkg::tile_t    hprev_tile_i,
    output logic                   stage_valid_o,
    output ssm_pkg::data_t         dx_o,
    output ssm_pkg::data_t         da_o,
    output ssm_pkg::data_t         xd_o,
    output ssm_pkg::tile_t         b_tile_o,
    output ssm_pkg::tile_t         c_tile_o,
    output ssm_pkg::tile_t         hprev_tile_o,
    output logic                   last_o
);
    import ssm_pkg::*;

    tile_idx_t tile_idx;
    logic      accept;
    logic      idx_last;

    // tile_ready is advance itself, so this is the transfer edge
    assign accept   = tile_valid_i & advance_i;
    assign idx_last = (tile_idx == tile_idx_t'(`SSM_TILES-1));

    // ====================
    // tile counter
    // ====================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tile_idx <= '0;
        end else if (accept) begin
            if (idx_last) begin
                tile_idx <= '0;
            end else begin
                tile_idx <= tile_idx + 1'b1;
            end
        end
    end

    // stage valid and group tag
    // a bubble enters the pipe when no tile is offered
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            stage_valid_o <= 1'b0;
            last_o        <= 1'b0;
        end else if (advance_i) begin
            stage_valid_o <= tile_valid_i;
            last_o        <= tile_valid_i & idx_last;
        end
    end

    // ====================
    // scalar products and tile registers
    // ====================
    always_ff @(posedge clk) begin
        if (accept) begin
            // dx per tile, scalars may change between tiles
            dx_o         <= q_mul(dt_i, x_i);
            da_o         <= da_i;
            b_tile_o     <= b_tile_i;
            c_tile_o     <= c_tile_i;
            hprev_tile_o <= hprev_tile_i;
            // xD only on the first tile, then held for the rest of the group
            if (tile_idx == '0) begin
                xd_o <= q_mul(x_i, d_i);
            end
        end
    end

endmodule

`default_nettype wire

/* design/ssm_lane.sv */
// ====================
// one state lane, two register stages under advance_i
// h_next and hc both wrap to 16 bits
// ====================
`timescale 1ns/1ps
`default_nettype none

module ssm_lane (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire                    advance_i,
    input  wire                    valid_i,
    input  wire ssm_pkg::data_t    dx_i,
    input  wire ssm_pkg::data_t    da_i,
    input  wire ssm_pkg::data_t    b_i,
    input  wire ssm_pkg::data_t    c_i,
    input  wire ssm_pkg::data_t    hprev_i,
    output ssm_pkg::data_t         hc_o,
    output logic                   valid_o
);
    import ssm_pkg::*;

    data_t h_next_d;
    data_t h_next_q;
    data_t c_q;
    logic  valid_q;

    // h_next = dA*hprev + dx*B
    // each product is scaled first, the sum wraps
    assign h_next_d = q_mul(da_i, hprev_i) + q_mul(dx_i, b_i);

    // ====================
    // valid pipe
    // ====================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= 1'b0;
            valid_o <= 1'b0;
        end else if (advance_i) begin
            valid_q <= valid_i;
            valid_o <= valid_q;
        end
    end

    // ====================
    // data pipe
    // ====================
    always_ff @(posedge clk) begin
        if (advance_i) begin
            // stage 1, C rides along with h_next
            h_next_q <= h_next_d;
            c_q      <= c_i;
            // stage 2
            hc_o     <= q_mul(h_next_q, c_q);
        end
    end

endmodule

`default_nettype wire

/* design/ssm_group_reduce.sv */
// ====================
// tile sum, group accumulation and held result
// y_o is held until y_ready_i; while held the whole pipe stalls
// the last tag and xD are aligned to the lane outputs here
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "ssm_macros.svh"

module ssm_group_reduce (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire                    lane_valid_i,
    input  wire                    last_i,
    input  wire ssm_pkg::data_t    xd_i,
    input  wire ssm_pkg::tile_t    hc_tile_i,
    input  wire                    y_ready_i,
    output logic                   advance_o,
    output ssm_pkg::acc_t          y_o,
    output logic                   y_valid_o
);
    import ssm_pkg::*;

    logic  last_pipe [`SSM_LANE_LAT];
    data_t xd_pipe   [`SSM_LANE_LAT];
    acc_t  acc;
    acc_t  tile_sum;
    logic  tile_last;
    data_t tile_xd;
    logic  tile_take;

    // sign extend one Q8.8 term to the accumulator width
    function automatic acc_t sext(input data_t v);
        return {{(`SSM_ACC_W-`SSM_DW){v[`SSM_DW-1]}}, v};
    endfunction

    // stall only when a result is held and not taken
    assign advance_o = ~(y_valid_o & ~y_ready_i);

    // ====================
    // tag delay
    // ====================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `SSM_LANE_LAT; i++) begin
                last_pipe[i] <= 1'b0;
            end
        end else if (advance_o) begin
            last_pipe[0] <= last_i;
            for (int i = 1; i < `SSM_LANE_LAT; i++) begin
                last_pipe[i] <= last_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance_o) begin
            xd_pipe[0] <= xd_i;
            for (int i = 1; i < `SSM_LANE_LAT; i++) begin
                xd_pipe[i] <= xd_pipe[i-1];
            end
        end
    end

    assign tile_last = last_pipe[`SSM_LANE_LAT-1];
    assign tile_xd   = xd_pipe[`SSM_LANE_LAT-1];
    assign tile_take = advance_o & lane_valid_i;

    // sum of the 16 lane products, each term sign extended
    always_comb begin
        tile_sum = '0;
        for (int i = 0; i < `SSM_LANES; i++) begin
            tile_sum = tile_sum + sext(data_t'(hc_tile_i[i*`SSM_DW +: `SSM_DW]));
        end
    end

    // ====================
    // group accumulation
    // ====================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            acc       <= '0;
            y_valid_o <= 1'b0;
        end else if (advance_o) begin
            // advance high with y_valid_o set means the result was taken
            y_valid_o <= tile_take & tile_last;
            if (tile_take) begin
                if (tile_last) begin
                    acc <= '0;
                end else begin
                    acc <= acc + tile_sum;
                end
            end
        end
    end

    // result register, closes the group with +xD
    always_ff @(posedge clk) begin
        if (tile_take & tile_last) begin
            y_o <= acc + tile_sum + sext(tile_xd);
        end
    end

endmodule

`default_nettype wire

/* design/ssm_block_top.sv */
// ====================
// one ssm recurrence step, one channel, 128 state elements
// tiles arrive 16 lanes wide, 8 tiles per group, one y per group
// tile_ready_o drops at once when a result is not taken
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "ssm_macros.svh"

module ssm_block_top (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire                    tile_valid_i,
    output logic                   tile_ready_o,
    input  wire ssm_pkg::data_t    dt_i,
    input  wire ssm_pkg::data_t    x_i,
    input  wire ssm_pkg::data_t    da_i,
    input  wire ssm_pkg::data_t    d_i,
    input  wire ssm_pkg::tile_t    b_tile_i,
    input  wire ssm_pkg::tile_t    c_tile_i,
    input  wire ssm_pkg::tile_t    hprev_tile_i,
    output ssm_pkg::acc_t          y_o,
    output logic                   y_valid_o,
    input  wire                    y_ready_i
);
    import ssm_pkg::*;

    // global stall driven by the reducer
    logic  advance;

    // input stage outputs
    logic  stage_valid;
    data_t dx;
    data_t da;
    data_t xd;
    tile_t b_tile;
    tile_t c_tile;
    tile_t hprev_tile;
    logic  last;

    // lane array outputs
    tile_t                 hc_tile;
    logic [`SSM_LANES-1:0] lane_valid;

    assign tile_ready_o = advance;

    // ====================
    // input stage
    // ====================
    ssm_tile_in u_tile_in (
        .clk          (clk),
        .rstn         (rstn),
        .advance_i    (advance),
        .tile_valid_i (tile_valid_i),
        .dt_i         (dt_i),
        .x_i          (x_i),
        .da_i         (da_i),
        .d_i          (d_i),
        .b_tile_i     (b_tile_i),
        .c_tile_i     (c_tile_i),
        .hprev_tile_i (hprev_tile_i),
        .stage_valid_o(stage_valid),
        .dx_o         (dx),
        .da_o         (da),
        .xd_o         (xd),
        .b_tile_o     (b_tile),
        .c_tile_o     (c_tile),
        .hprev_tile_o (hprev_tile),
        .last_o       (last)
    );

    // ====================
    // lane array
    // ====================
    for (genvar i = 0; i < `SSM_LANES; i++) begin : g_lane
        ssm_lane u_lane (
            .clk      (clk),
            .rstn     (rstn),
            .advance_i(advance),
            .valid_i  (stage_valid),
            .dx_i     (dx),
            .da_i     (da),
            .b_i      (b_tile[i*`SSM_DW +: `SSM_DW]),
            .c_i      (c_tile[i*`SSM_DW +: `SSM_DW]),
            .hprev_i  (hprev_tile[i*`SSM_DW +: `SSM_DW]),
            .hc_o     (hc_tile[i*`SSM_DW +: `SSM_DW]),
            .valid_o  (lane_valid[i])
        );
    end

    // ====================
    // reducer
    // ====================
    // the lanes run in lockstep so their valids agree
    ssm_group_reduce u_reduce (
        .clk         (clk),
        .rstn        (rstn),
        .lane_valid_i(&lane_valid),
        .last_i      (last),
        .xd_i        (xd),
        .hc_tile_i   (hc_tile),
        .y_ready_i   (y_ready_i),
        .advance_o   (advance),
        .y_o         (y_o),
        .y_valid_o   (y_valid_o)
    );

endmodule

`default_nettype wire

/* test/ssm_block_properties.sv */
// ====================
// handshake and reset properties of the ssm block
// attached to ssm_block_top by bind, sampled on the rising edge
// ====================
`timescale 1ns/1ps
`default_nettype none

module ssm_block_properties (
    input wire                 clk,
    input wire                 rstn,
    input wire                 tile_ready_o,
    input wire                 y_valid_o,
    input wire                 y_ready_i,
    input wire ssm_pkg::acc_t  y_o
);

    // number of failed properties, read at the end of the run
    int fail_count = 0;

    // nothing pending on the first edge out of reset
    assert property (@(posedge clk) $rose(rstn) |-> !y_valid_o && tile_ready_o)
        else begin
            $error("result valid or input stalled right after reset");
            fail_count++;
        end

    // a result that is not taken stays put
    assert property (@(posedge clk) disable iff (!rstn)
        y_valid_o && !y_ready_i |=> y_valid_o && $stable(y_o))
        else begin
            $error("held result changed before it was taken");
            fail_count++;
        end

    // input stalls exactly while a result waits
    assert property (@(posedge clk) disable iff (!rstn)
        tile_ready_o == !(y_valid_o && !y_ready_i))
        else begin
            $error("tile_ready_o does not follow the result stall");
            fail_count++;
        end

endmodule

bind ssm_block_top ssm_block_properties u_props (
    .clk         (clk),
    .rstn        (rstn),
    .tile_ready_o(tile_ready_o),
    .y_valid_o   (y_valid_o),
    .y_ready_i   (y_ready_i),
    .y_o         (y_o)
);

`default_nettype wire

/* test/ssm_block_tb.sv */
// ====================
// testbench for ssm_block_top, one channel, 8 tiles per group
// expected y comes from a Q8.8 model of the arithmetic rules
// groups are always sent complete
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "ssm_macros.svh"

module ssm_block_tb;
    import ssm_pkg::*;

    logic  clk;
    logic  rstn;
    logic  tile_valid_i;
    logic  tile_ready_o;
    logic  y_valid_o;
    logic  y_ready_i;
    data_t dt_i;
    data_t x_i;
    data_t da_i;
    data_t d_i;
    tile_t b_tile_i;
    tile_t c_tile_i;
    tile_t hprev_tile_i;
    acc_t  y_o;

    // one group of stimulus indexed by tile
    data_t g_dt [`SSM_TILES];
    data_t g_x  [`SSM_TILES];
    data_t g_da [`SSM_TILES];
    data_t g_d  [`SSM_TILES];
    tile_t g_b  [`SSM_TILES];
    tile_t g_c  [`SSM_TILES];
    tile_t g_h  [`SSM_TILES];

    acc_t        exp_q [$];
    logic [31:0] lfsr = 32'h6201;
    string       test_name;
    int          errors;
    int          checks;
    int          got;

    ssm_block_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ====================
    // stimulus and model
    // ====================
    // galois lfsr stepped once per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    // mode 0 is hand-picked, 1 is about +-4.0 and 2 the full 16 bit range
    function automatic data_t pick(input int mode, input data_t fixed);
        logic [15:0] r;
        case (mode)
            0: pick = fixed;
            1: begin
                r = rand_bits(11);
                pick = {{5{r[10]}}, r[10:0]};
            end
            default: pick = rand_bits(16);
        endcase
    endfunction

    // full 32 bit product shifted by 8 with the low 16 bits kept
    function automatic data_t fx_mul(input data_t a, input data_t b);
        int full;
        full = int'(a) * int'(b);
        return data_t'(full >>> `SSM_FRAC);
    endfunction

    // fills one group and queues its expected y
    task automatic make_group(input int mode);
        acc_t  y;
        data_t dx;
        data_t b;
        data_t c;
        data_t hp;
        data_t h;
        y = '0;
        for (int t = 0; t < `SSM_TILES; t++) begin
            g_dt[t] = pick(mode, 16'h0100);
            g_x[t]  = pick(mode, 16'h0200);
            g_da[t] = pick(mode, 16'hff80);
            // later D values must not reach y
            g_d[t]  = pick(mode, (t == 0) ? 16'h0100 : 16'h0300);
            dx = fx_mul(g_dt[t], g_x[t]);
            if (t == 0) begin
                y = y + acc_t'(fx_mul(g_x[t], g_d[t]));
            end
            for (int l = 0; l < `SSM_LANES; l++) begin
                b  = pick(mode, (l == 1) ? 16'hff80 : 16'h0200);
                c  = pick(mode, (l == 3) ? 16'hff80 : 16'h0100);
                hp = pick(mode, 16'h0100);
                g_b[t][l*`SSM_DW +: `SSM_DW] = b;
                g_c[t][l*`SSM_DW +: `SSM_DW] = c;
                g_h[t][l*`SSM_DW +: `SSM_DW] = hp;
                // h_next wraps to 16 bits before the C product
                h = fx_mul(g_da[t], hp) + fx_mul(dx, b);
                y = y + acc_t'(fx_mul(h, c));
            end
        end
        exp_q.push_back(y);
    endtask

    // ====================
    // driver and monitor
    // ====================
    // called 2 ns after a rising edge and returns the same way
    task automatic send_group(input bit gaps);
        int n;
        for (int t = 0; t < `SSM_TILES; t++) begin
            repeat (gaps ? rand_bits(2) : 0) begin
                @(posedge clk);
                #2;
            end
            tile_valid_i = 1'b1;
            dt_i         = g_dt[t];
            x_i          = g_x[t];
            da_i         = g_da[t];
            d_i          = g_d[t];
            b_tile_i     = g_b[t];
            c_tile_i     = g_c[t];
            hprev_tile_i = g_h[t];
            n = 0;
            @(negedge clk);
            while (!tile_ready_o && n < 200) begin
                @(negedge clk);
                n++;
            end
            if (!tile_ready_o) begin
                $display("tile %0d not accepted within timeout in %s", t, test_name);
                errors++;
            end
            @(posedge clk);
            #2;
            tile_valid_i = 1'b0;
        end
    endtask

    // a transfer happens on the next edge and y_o is stable here
    always @(negedge clk) begin
        if (rstn && y_valid_o && y_ready_i) begin
            got++;
            if (exp_q.size() == 0) begin
                $display("result %0d arrived with none expected in %s", y_o, test_name);
                errors++;
            end else begin
                checks++;
                assert (y_o == exp_q[0]) else begin
                    $display("mismatch in %s: expected %0d actual %0d",
                             test_name, exp_q[0], y_o);
                    errors++;
                end
                void'(exp_q.pop_front());
            end
        end
    end

    task automatic finish_test();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 400) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("no result within timeout in %s", test_name);
            errors++;
            exp_q.delete();
        end
        @(posedge clk);
        #2;
        $display("test %s finished, errors so far %0d", test_name, errors);
    endtask

    // ====================
    // tests
    // ====================
    initial begin
        int   n;
        int   lat;
        acc_t held;
        rstn         = 1'b0;
        tile_valid_i = 1'b0;
        y_ready_i    = 1'b1;
        dt_i         = '0;
        x_i          = '0;
        da_i         = '0;
        d_i          = '0;
        b_tile_i     = '0;
        c_tile_i     = '0;
        hprev_tile_i = '0;
        repeat (2) @(posedge clk);
        #2;
        rstn = 1'b1;

        test_name = "reset_state";
        checks++;
        assert (!y_valid_o && tile_ready_o) else begin
            $display("wrong handshake state after reset in %s", test_name);
            errors++;
        end
        finish_test();

        test_name = "hand_picked";
        make_group(0);
        send_group(1'b0);
        // cycles since the last accept edge where the first one counts as 1
        lat = 1;
        @(negedge clk);
        while (!y_valid_o && lat < 20) begin
            @(negedge clk);
            lat++;
        end
        checks++;
        assert (lat == 4) else begin
            $display("mismatch in %s latency: expected %0d actual %0d", test_name, 4, lat);
            errors++;
        end
        finish_test();

        test_name = "back_to_back";
        repeat (4) begin
            make_group(1);
            send_group(1'b0);
        end
        finish_test();

        test_name = "random_gaps";
        repeat (4) begin
            make_group(1);
            send_group(1'b1);
        end
        finish_test();

        test_name = "back_pressure";
        y_ready_i = 1'b0;
        fork
            repeat (3) begin
                make_group(1);
                send_group(1'b0);
            end
            begin
                n = 0;
                @(negedge clk);
                while (!y_valid_o && n < 200) begin
                    @(negedge clk);
                    n++;
                end
                if (!y_valid_o) begin
                    $display("no result within timeout in %s", test_name);
                    errors++;
                end
                held = y_o;
                // tiles keep coming while the result waits
                repeat (6) begin
                    @(negedge clk);
                    checks++;
                    assert (!tile_ready_o && y_valid_o && y_o == held) else begin
                        $display("result not held under back-pressure in %s", test_name);
                        errors++;
                    end
                end
                @(posedge clk);
                #2;
                y_ready_i = 1'b1;
            end
        join
        finish_test();

        // products and h_next overflow and wrap
        test_name = "large_values";
        repeat (3) begin
            make_group(2);
            send_group(1'b0);
        end
        finish_test();

        if (dut.u_props.fail_count != 0) begin
            $display("%0d handshake property failures", dut.u_props.fail_count);
            errors += dut.u_props.fail_count;
        end

        $display("checks %0d, results %0d, errors %0d", checks, got, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+design
design/ssm_pkg.sv
design/ssm_tile_in.sv
design/ssm_lane.sv
design/ssm_group_reduce.sv
design/ssm_block_top.sv
test/ssm_block_properties.sv
test/ssm_block_tb.sv

/* Bender.yml */
package:
  name: ssm_block

sources:
  - include_dirs:
      - design
    files:
      - design/ssm_pkg.sv
      - design/ssm_tile_in.sv
      - design/ssm_lane.sv
      - design/ssm_group_reduce.sv
      - design/ssm_block_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/ssm_block_properties.sv
      - test/ssm_block_tb.sv
